// File: list.f
+incdir+hw
hw/cachePkg.sv
hw/tagStore.sv
hw/dataStore.sv
hw/victimSelect.sv
hw/cacheControl.sv
hw/cacheTop.sv
dv/cacheProps.sv
dv/cacheTb.sv

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module cacheTb \
    -f list.f \
    -o cacheSim

./obj_dir/cacheSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification passed" sim.log; then
    exit 0
else
    exit 1
fi

// File: dv/cacheTb.sv
`timescale 1ns/10ps

module cacheTb;
    import cachePkg::*;

    localparam int timeoutCycles = 2000;

    logic clock;
    logic reset;
    cpuReqT cpuReq;
    wordT cpuData;
    logic cpuDone;
    memAddrT memAr;
    memAddrT memAw;
    logic arReady;
    logic awReady;
    logic wReady;
    memWriteT memW;
    memReadT memR;
    logic rReady;

    // architectural view and what the bus memory holds
    logic [7:0] refBytes [addrT];
    logic [7:0] busBytes [addrT];
    // lines holding writes not yet written back
    logic dirtyLines [addrT];

    integer seed = 81542;
    logic randomDelays;
    int errors;
    int checks;
    int testsRun;
    int wbCount;

    // responder state
    addrT wbAddr;
    int wbBeat;
    addrT rdAddr;
    int rdBeat;
    logic rdPending;
    logic rTaken;

    cacheTop DUT (
        .clock(clock),
        .reset(reset),
        .cpuReq(cpuReq),
        .cpuData(cpuData),
        .cpuDone(cpuDone),
        .memAr(memAr),
        .memAw(memAw),
        .arReady(arReady),
        .awReady(awReady),
        .wReady(wReady),
        .memW(memW),
        .memR(memR),
        .rReady(rReady)
    );

    always #20 clock = !clock;

    // fill pattern over all address bits
    function automatic logic [7:0] patternByte(addrT a);
        return (a[7:0] * 8'd13) ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h3c;
    endfunction

    function automatic logic [7:0] refByte(addrT a);
        return refBytes.exists(a) ? refBytes[a] : patternByte(a);
    endfunction

    function automatic logic [7:0] busByte(addrT a);
        return busBytes.exists(a) ? busBytes[a] : patternByte(a);
    endfunction

    function automatic wordT refWord(addrT a);
        wordT w;
        for (int i = 0; i < 8; i++) begin
            w[i*8 +: 8] = refByte(a + addrT'(i));
        end
        return w;
    endfunction

    function automatic wordT busWord(addrT a);
        wordT w;
        for (int i = 0; i < 8; i++) begin
            w[i*8 +: 8] = busByte(a + addrT'(i));
        end
        return w;
    endfunction

    // bytes from the offset on and zero past the line end
    function automatic wordT expectRead(addrT a);
        wordT w;
        addrT base;
        int off;
        base = {a[31:4], 4'h0};
        for (int i = 0; i < 8; i++) begin
            off = int'(a[3:0]) + i;
            w[i*8 +: 8] = (off < 16) ? refByte(base + addrT'(off)) : 8'h00;
        end
        return w;
    endfunction

    // only the four supported masks land and are clipped at the line end
    function automatic void applyWrite(addrT a, wordT d, byteMaskT m);
        addrT base;
        int off;
        base = {a[31:4], 4'h0};
        if (m == 8'h01 || m == 8'h03 || m == 8'h0f || m == 8'hff) begin
            for (int i = 0; i < 8; i++) begin
                off = int'(a[3:0]) + i;
                if (m[i] && off < 16) begin
                    refBytes[base + addrT'(off)] = d[i*8 +: 8];
                end
            end
        end
    endfunction

    task automatic compareWord(input string name, input wordT got, input wordT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareAddr(input string name, input addrT got, input addrT exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compareBit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // memory side with handshakes sampled mid cycle
    always begin
        @(negedge clock);
        rTaken = 1'b0;
        if (!reset && memAw.valid && awReady) begin
            wbAddr = memAw.addr;
            wbBeat = 0;
            // victim sits in the requested set and was written since reset
            compareAddr("memAw.addr", memAw.addr, {memAw.addr[31:8], cpuReq.addr[7:4], 4'h0});
            compareBit("memAw.addr dirty", dirtyLines.exists(memAw.addr) != 0, 1'b1);
            dirtyLines.delete(memAw.addr);
        end
        if (!reset && memW.valid && wReady) begin
            // dirty line must match the architectural copy
            compareWord("memW.data", memW.data, refWord(wbAddr + addrT'(wbBeat * 8)));
            compareBit("memW.last", memW.last, wbBeat == 1);
            for (int i = 0; i < 8; i++) begin
                busBytes[wbAddr + addrT'(wbBeat * 8 + i)] = memW.data[i*8 +: 8];
            end
            wbBeat++;
            if (wbBeat == 2) begin
                wbCount++;
            end
        end
        if (!reset && memAr.valid && arReady) begin
            // refill fetches the line of the pending request
            compareAddr("memAr.addr", memAr.addr, {cpuReq.addr[31:4], 4'h0});
            rdAddr = memAr.addr;
            rdBeat = 0;
            rdPending = 1'b1;
        end
        if (!reset && rReady && memR.valid) begin
            rTaken = 1'b1;
            rdBeat++;
            if (rdBeat == 2) begin
                rdPending = 1'b0;
            end
        end
        @(posedge clock);
        #2;
        arReady = randomDelays ? 1'($random(seed)) : 1'b1;
        awReady = randomDelays ? 1'($random(seed)) : 1'b1;
        wReady = randomDelays ? 1'($random(seed)) : 1'b1;
        if (rTaken || reset) begin
            memR.valid = 1'b0;
        end
        // data held until rReady takes it
        if (rdPending && !memR.valid && (!randomDelays || 1'($random(seed)))) begin
            memR.valid = 1'b1;
            memR.data = busWord(rdAddr + addrT'(rdBeat * 8));
            memR.last = rdBeat == 1;
        end
    end

    task automatic applyReset();
        reset = 1'b1;
        rdPending = 1'b0;
        repeat (16) @(posedge clock);
        #2;
        reset = 1'b0;
        // dirty lines are lost and the cache starts from memory again
        refBytes = busBytes;
        dirtyLines.delete();
    endtask

    // one request held until cpuDone with cycles counted from the drive
    task automatic access(input logic wr, input addrT a, input wordT d, input byteMaskT m,
                          output wordT data, output int cycles);
        logic done;
        @(posedge clock);
        #2;
        cpuReq.valid = 1'b1;
        cpuReq.write = wr;
        cpuReq.addr = a;
        cpuReq.wdata = d;
        cpuReq.wmask = m;
        cycles = 0;
        done = 1'b0;
        data = '0;
        while (cycles < timeoutCycles && !done) begin
            @(negedge clock);
            cycles++;
            if (cpuDone) begin
                done = 1'b1;
                data = cpuData;
            end
        end
        @(posedge clock);
        #2;
        cpuReq.valid = 1'b0;
        if (!done) begin
            errors++;
            $display("%0t: access to %h got no cpuDone within %0d cycles", $time, a, cycles);
        end
    endtask

    task automatic readCheck(input addrT a, output int cycles);
        wordT data;
        access(1'b0, a, '0, '0, data, cycles);
        compareWord("cpuData", data, expectRead(a));
    endtask

    task automatic writeWord(input addrT a, input wordT d, input byteMaskT m);
        wordT data;
        int cycles;
        access(1'b1, a, d, m, data, cycles);
        applyWrite(a, d, m);
        // any mask marks the line dirty
        dirtyLines[{a[31:4], 4'h0}] = 1'b1;
    endtask

    task automatic report(input string name, input int startErrors);
        testsRun++;
        $display("test %s: %0d errors", name, errors - startErrors);
    endtask

    task automatic resetCheckTest();
        int start;
        int cycles;
        start = errors;
        applyReset();
        @(negedge clock);
        compareBit("memAr.valid", memAr.valid, 1'b0);
        compareBit("memAw.valid", memAw.valid, 1'b0);
        compareBit("memW.valid", memW.valid, 1'b0);
        compareBit("rReady", rReady, 1'b0);
        compareBit("cpuDone", cpuDone, 1'b0);
        readCheck(32'h0000_1230, cycles);
        report("reset and first read", start);
    endtask

    task automatic repeatHitTest();
        int start;
        int cycles;
        start = errors;
        readCheck(32'h0000_1230, cycles);
        // idle cycle then done in lookup
        compareBit("one cycle hit", cycles == 2, 1'b1);
        report("repeated read hit", start);
    endtask

    task automatic writeMaskTest();
        int start;
        int cycles;
        start = errors;
        writeWord(32'h0000_3453, 64'h1111_2222_3333_44a1, 8'h01);
        writeWord(32'h0000_3456, 64'h5555_6666_7777_b2c3, 8'h03);
        writeWord(32'h0000_345a, 64'h8888_9999_d4e5_f607, 8'h0f);
        // crosses the line end
        writeWord(32'h0000_345c, 64'h0123_4567_89ab_cdef, 8'hff);
        writeWord(32'h0000_3450, 64'hdead_beef_cafe_f00d, 8'h55);
        readCheck(32'h0000_3450, cycles);
        readCheck(32'h0000_3458, cycles);
        readCheck(32'h0000_3453, cycles);
        readCheck(32'h0000_345a, cycles);
        report("write masks", start);
    endtask

    task automatic evictionTest();
        int start;
        int wbStart;
        int cycles;
        addrT a;
        start = errors;
        wbStart = wbCount;
        for (int i = 0; i < 5; i++) begin
            a = {24'h000100 + 24'(i), 4'h5, 4'h0};
            writeWord(a, {32'hfeed_0000 + 32'(i), 32'h0bad_0000 + 32'(i)}, 8'hff);
        end
        for (int i = 0; i < 5; i++) begin
            a = {24'h000100 + 24'(i), 4'h5, 4'h0};
            readCheck(a, cycles);
        end
        if (wbCount == wbStart) begin
            errors++;
            $display("%0t: five dirty lines in one set caused no write-back", $time);
        end
        report("dirty evictions", start);
    endtask

    task automatic offsetReadTest();
        int start;
        int cycles;
        start = errors;
        readCheck(32'h0000_2344, cycles);
        readCheck(32'h0000_2348, cycles);
        readCheck(32'h0000_234c, cycles);
        report("offset reads", start);
    endtask

    task automatic runAll();
        resetCheckTest();
        repeatHitTest();
        writeMaskTest();
        evictionTest();
        offsetReadTest();
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        cpuReq = '0;
        arReady = 1'b0;
        awReady = 1'b0;
        wReady = 1'b0;
        memR = '0;
        rdPending = 1'b0;
        rTaken = 1'b0;
        wbBeat = 0;
        rdBeat = 0;
        wbAddr = '0;
        rdAddr = '0;
        errors = 0;
        checks = 0;
        testsRun = 0;
        wbCount = 0;
        randomDelays = 1'b0;
        runAll();
        // same tests under random back-pressure
        randomDelays = 1'b1;
        runAll();
        $display("tests %0d, checks %0d, errors %0d", testsRun, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: dv/cacheProps.sv
`timescale 1ns/10ps

module cacheProps (
    input logic               clock,
    input logic               reset,
    input cachePkg::memAddrT  memAr,
    input cachePkg::memAddrT  memAw,
    input cachePkg::memWriteT memW,
    input logic               rReady,
    input logic               arReady
);
    import cachePkg::*;

    // last beat flag only on a live beat
    lastNeedsValid: assert property (@(posedge clock) disable iff (reset)
        memW.last |-> memW.valid)
        else $error("memW.last without memW.valid");

    // one address channel at a time
    oneAddrChannel: assert property (@(posedge clock) disable iff (reset)
        !(memAr.valid && memAw.valid))
        else $error("memAr.valid and memAw.valid both high");

    // refill never overlaps a pending write-back address
    readyNotInWriteBack: assert property (@(posedge clock) disable iff (reset)
        rReady |-> !memAw.valid)
        else $error("rReady high while memAw.valid");

    // read address held until taken
    arHeld: assert property (@(posedge clock) disable iff (reset)
        memAr.valid && !arReady |=> memAr.valid)
        else $error("memAr.valid dropped before arReady");

endmodule

bind cacheControl cacheProps props (
    .clock(clock),
    .reset(reset),
    .memAr(memAr),
    .memAw(memAw),
    .memW(memW),
    .rReady(rReady),
    .arReady(arReady)
);

// File: hw/cacheTop.sv
`timescale 1ns/10ps

module cacheTop (
    input  logic               clock,
    input  logic               reset,
    input  cachePkg::cpuReqT   cpuReq,
    output cachePkg::wordT     cpuData,
    output logic               cpuDone,
    output cachePkg::memAddrT  memAr,
    output cachePkg::memAddrT  memAw,
    input  logic               arReady,
    input  logic               awReady,
    input  logic               wReady,
    output cachePkg::memWriteT memW,
    input  cachePkg::memReadT  memR,
    output logic               rReady
);
    import cachePkg::*;

    // lookup results
    logic hit;
    wayT hitWay;
    tagT victimTag;
    logic victimDirty;
    wayT victimWay;

    // tag store strobes
    logic capture;
    logic fillEn;
    logic markDirty;
    logic cleanEn;

    // data array port
    slotT slot;
    logic writeEn;
    lineT writeLine;
    lineMaskT byteEn;
    lineT readLine;

    cacheControl control (
        .clock(clock),
        .reset(reset),
        .cpuReq(cpuReq),
        .cpuData(cpuData),
        .cpuDone(cpuDone),
        .hit(hit),
        .hitWay(hitWay),
        .victimWay(victimWay),
        .victimTag(victimTag),
        .victimDirty(victimDirty),
        .capture(capture),
        .fillEn(fillEn),
        .markDirty(markDirty),
        .cleanEn(cleanEn),
        .slot(slot),
        .writeEn(writeEn),
        .writeLine(writeLine),
        .byteEn(byteEn),
        .readLine(readLine),
        .memAr(memAr),
        .memAw(memAw),
        .memW(memW),
        .rReady(rReady),
        .arReady(arReady),
        .awReady(awReady),
        .wReady(wReady),
        .memR(memR)
    );

    // tags compare against the live request address
    tagStore tags (
        .clock(clock),
        .reset(reset),
        .lookupAddr(cpuReq.addr),
        .victimWay(victimWay),
        .fillEn(fillEn),
        .markDirty(markDirty),
        .cleanEn(cleanEn),
        .hit(hit),
        .hitWay(hitWay),
        .victimTag(victimTag),
        .victimDirty(victimDirty)
    );

    dataStore data (
        .clock(clock),
        .slot(slot),
        .writeEn(writeEn),
        .writeLine(writeLine),
        .byteEn(byteEn),
        .readLine(readLine)
    );

    victimSelect victim (
        .clock(clock),
        .reset(reset),
        .capture(capture),
        .victimWay(victimWay)
    );

endmodule

// File: hw/cacheControl.sv
`timescale 1ns/10ps
`include "cacheConsts.svh"

module cacheControl (
    input  logic               clock,
    input  logic               reset,
    input  cachePkg::cpuReqT   cpuReq,
    output cachePkg::wordT     cpuData,
    output logic               cpuDone,
    input  logic               hit,
    input  cachePkg::wayT      hitWay,
    input  cachePkg::wayT      victimWay,
    input  cachePkg::tagT      victimTag,
    input  logic               victimDirty,
    output logic               capture,
    output logic               fillEn,
    output logic               markDirty,
    output logic               cleanEn,
    output cachePkg::slotT     slot,
    output logic               writeEn,
    output cachePkg::lineT     writeLine,
    output cachePkg::lineMaskT byteEn,
    input  cachePkg::lineT     readLine,
    output cachePkg::memAddrT  memAr,
    output cachePkg::memAddrT  memAw,
    output cachePkg::memWriteT memW,
    output logic               rReady,
    input  logic               arReady,
    input  logic               awReady,
    input  logic               wReady,
    input  cachePkg::memReadT  memR
);
    import cachePkg::*;

    cacheStateT state;
    cacheStateT nextState;
    // beat within the current burst
    logic beat;

    setT reqSet;
    tagT reqTag;
    logic [`offsetBits-1:0] byteOffset;
    logic [`offsetBits+2:0] bitOffset;
    lineT shifted;
    lineT placedData;
    lineMaskT placedMask;
    lineMaskT refillMask;
    logic writeHit;
    logic arFire;
    logic awFire;
    logic wFire;
    logic rFire;
    logic lastW;

    assign reqTag = cpuReq.addr[`addrBits-1 -: $bits(tagT)];
    assign reqSet = cpuReq.addr[`offsetBits +: `setBits];
    assign byteOffset = cpuReq.addr[`offsetBits-1:0];
    assign bitOffset = {byteOffset, 3'b000};

    // handshakes
    assign arFire = memAr.valid && arReady;
    assign awFire = memAw.valid && awReady;
    assign wFire = memW.valid && wReady;
    assign rFire = rReady && memR.valid;
    assign lastW = beat == 1'(`burstBeats - 1);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                if (cpuReq.valid) begin
                    nextState = lookup;
                end
            end
            lookup: begin
                nextState = hit ? idle : miss;
            end
            // dirty victim goes out first, then back here for the refill
            miss: begin
                if (victimDirty) begin
                    if (awFire) begin
                        nextState = writeBack;
                    end
                end else if (arFire) begin
                    nextState = refill;
                end
            end
            writeBack: begin
                if (wFire && lastW) begin
                    nextState = miss;
                end
            end
            // retry the lookup, it hits now
            refill: begin
                if (rFire && memR.last) begin
                    nextState = lookup;
                end
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    // beat counter, shared by both bursts
    always_ff @(posedge clock) begin
        if (reset) begin
            beat <= 1'b0;
        end else if ((wFire && lastW) || (rFire && memR.last)) begin
            beat <= 1'b0;
        end else if (wFire || rFire) begin
            beat <= 1'b1;
        end
    end

    // read path, bytes past the line end shift in as zero
    assign shifted = readLine >> bitOffset;
    assign cpuData = shifted[`wordBits-1:0];
    assign cpuDone = (state == lookup) && hit;

    // write hit, data and mask placed at the byte offset
    assign writeHit = (state == lookup) && hit && cpuReq.write;
    assign placedData = lineT'(cpuReq.wdata) << bitOffset;

    always_comb begin
        case (cpuReq.wmask)
            8'h01, 8'h03, 8'h0f, 8'hff: begin
                placedMask = lineMaskT'(cpuReq.wmask) << byteOffset;
            end
            // other masks write nothing
            default: begin
                placedMask = '0;
            end
        endcase
    end

    // refill beat 0 fills the low word, beat 1 the high word
    assign refillMask = {{(`wordBits/8){beat}}, {(`wordBits/8){!beat}}};

    // tag store strobes
    assign capture = (state == lookup) && !hit;
    assign fillEn = rFire;
    assign markDirty = writeHit;
    assign cleanEn = wFire && lastW;

    // hit way while looking up, victim way through the miss
    assign slot = (state == idle || state == lookup) ? {reqSet, hitWay} : {reqSet, victimWay};
    assign writeEn = writeHit || rFire;
    assign writeLine = rFire ? {memR.data, memR.data} : placedData;
    assign byteEn = rFire ? refillMask : placedMask;

    // bus channels, line aligned addresses
    always_comb begin
        memAw.valid = (state == miss) && victimDirty;
        memAw.addr = {victimTag, reqSet, {`offsetBits{1'b0}}};
        memAr.valid = (state == miss) && !victimDirty;
        memAr.addr = {reqTag, reqSet, {`offsetBits{1'b0}}};
        // victim row was read in miss, low word goes first
        memW.valid = state == writeBack;
        memW.data = beat ? readLine[`lineBits-1 -: `wordBits] : readLine[`wordBits-1:0];
        memW.last = (state == writeBack) && lastW;
        rReady = state == refill;
    end

endmodule

// File: hw/victimSelect.sv
`timescale 1ns/10ps
`include "cacheConsts.svh"

module victimSelect (
    input  logic          clock,
    input  logic          reset,
    input  logic          capture,
    output cachePkg::wayT victimWay
);

    // fibonacci LFSR, shifts right
    logic [15:0] lfsr;
    logic feedback;

    assign feedback = lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5];

    // free running, one step per cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            lfsr <= 16'(`lfsrSeed);
        end else begin
            lfsr <= {feedback, lfsr[15:1]};
        end
    end

    // way stays put for the whole miss
    always_ff @(posedge clock) begin
        if (reset) begin
            victimWay <= '0;
        end else if (capture) begin
            victimWay <= lfsr[`wayBits-1:0];
        end
    end

endmodule

// File: hw/dataStore.sv
`timescale 1ns/10ps
`include "cacheConsts.svh"

module dataStore (
    input  logic               clock,
    input  cachePkg::slotT     slot,
    input  logic               writeEn,
    input  cachePkg::lineT     writeLine,
    input  cachePkg::lineMaskT byteEn,
    output cachePkg::lineT     readLine
);
    import cachePkg::*;

    // line array, contents guarded by tag valid bits
    lineT rows [`cacheSets * `cacheWays];
    // addressed row with this cycle's write applied
    lineT merged;

    always_comb begin
        merged = rows[slot];
        for (int b = 0; b < `lineBits / 8; b++) begin
            if (writeEn && byteEn[b]) begin
                merged[b*8 +: 8] = writeLine[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (writeEn) begin
            rows[slot] <= merged;
        end
    end

    // registered read, new data wins on a same-row write
    always_ff @(posedge clock) begin
        readLine <= merged;
    end

endmodule

// File: hw/tagStore.sv
`timescale 1ns/10ps
`include "cacheConsts.svh"

module tagStore (
    input  logic           clock,
    input  logic           reset,
    input  cachePkg::addrT lookupAddr,
    input  cachePkg::wayT  victimWay,
    input  logic           fillEn,
    input  logic           markDirty,
    input  logic           cleanEn,
    output logic           hit,
    output cachePkg::wayT  hitWay,
    output cachePkg::tagT  victimTag,
    output logic           victimDirty
);
    import cachePkg::*;

    localparam int slots = `cacheSets * `cacheWays;

    // one entry per slot, row = {set, way}
    tagT tags [slots];
    logic [slots-1:0] valid;
    logic [slots-1:0] dirty;
    // high between the two refill beats
    logic fillPhase;

    tagT reqTag;
    setT reqSet;
    logic [`cacheWays-1:0] wayHit;
    slotT hitSlot;
    slotT victimSlot;

    assign reqTag = lookupAddr[`addrBits-1 -: $bits(tagT)];
    assign reqSet = lookupAddr[`offsetBits +: `setBits];

    // compare all ways of the set at once
    always_comb begin
        for (int w = 0; w < `cacheWays; w++) begin
            wayHit[w] = valid[{reqSet, wayT'(w)}] && (tags[{reqSet, wayT'(w)}] == reqTag);
        end
    end

    // highest hitting way wins
    always_comb begin
        hitWay = '0;
        for (int w = 0; w < `cacheWays; w++) begin
            if (wayHit[w]) begin
                hitWay = wayT'(w);
            end
        end
    end

    assign hit = |wayHit;
    assign hitSlot = {reqSet, hitWay};
    assign victimSlot = {reqSet, victimWay};

    // victim status for the write-back decision
    assign victimTag = tags[victimSlot];
    assign victimDirty = valid[victimSlot] && dirty[victimSlot];

    // new tag goes in on the first refill beat
    always_ff @(posedge clock) begin
        if (fillEn && !fillPhase) begin
            tags[victimSlot] <= reqTag;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= '0;
            dirty <= '0;
            fillPhase <= 1'b0;
        end else begin
            // line invalid mid-fill, valid again on the last beat
            if (fillEn) begin
                fillPhase <= !fillPhase;
                valid[victimSlot] <= fillPhase;
            end
            if (markDirty) begin
                dirty[hitSlot] <= 1'b1;
            end
            // write-back done
            if (cleanEn) begin
                dirty[victimSlot] <= 1'b0;
            end
        end
    end

endmodule

// File: hw/cachePkg.sv
`include "cacheConsts.svh"

package cachePkg;

    // plain vectors with a meaning
    typedef logic [`addrBits-1:0] addrT;
    typedef logic [`wordBits-1:0] wordT;
    typedef logic [`lineBits-1:0] lineT;
    typedef logic [`lineBits/8-1:0] lineMaskT;
    typedef logic [`wordBits/8-1:0] byteMaskT;
    typedef logic [`addrBits-`setBits-`offsetBits-1:0] tagT;
    typedef logic [`setBits-1:0] setT;
    typedef logic [`wayBits-1:0] wayT;
    // set index above way number
    typedef logic [`setBits+`wayBits-1:0] slotT;

    // processor request, held until done
    typedef struct packed {
        logic     valid;
        logic     write;
        addrT     addr;
        wordT     wdata;
        byteMaskT wmask;
    } cpuReqT;

    // read or write address channel
    typedef struct packed {
        logic valid;
        addrT addr;
    } memAddrT;

    // write data channel
    typedef struct packed {
        logic valid;
        wordT data;
        logic last;
    } memWriteT;

    // read data channel
    typedef struct packed {
        logic valid;
        wordT data;
        logic last;
    } memReadT;

    typedef enum logic [2:0] {
        idle,
        lookup,
        miss,
        writeBack,
        refill
    } cacheStateT;

endpackage

// File: hw/cacheConsts.svh
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// cache geometry
`define cacheWays 4
`define cacheSets 16

// address split, tag takes the rest
`define offsetBits 4
`define setBits 4
`define wayBits 2
`define addrBits 32

// data widths
`define wordBits 64
`define lineBits 128

// two beats of one word each
`define burstBeats 2

// victim LFSR state after reset
`define lfsrSeed 1

`endif
